// File: Makefile
# Verilator build and run of the AXI4-Lite UART testbench
# any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= uart_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

FAIL_MSG := *** TEST FAILED ***
PASS_MSG := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "simulation did not finish, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
+incdir+source
source/uart_line_pkg.sv
source/axil_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_axil_regs.sv
source/uart_axil_top.sv
tests/uart_assertions.sv
tests/uart_tb.sv

// File: source/axil_pkg.sv
/*
 AXI4-Lite bus side types, with response codes and the UART register map
*/
`include "uart_defines.svh"

package axil_pkg;

  // only the two codes this slave returns
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_t;

  // word addresses of the register map
  typedef enum logic [`AXIL_ADDR_WIDTH-1:0] {
    TX_DATA = 'h0,
    RX_DATA = 'h4,
    STATUS  = 'h8
  } reg_addr_t;

endpackage

// File: source/uart_axil_regs.sv
/*
 AXI4-Lite register block for the UART: TX/RX data, status and
 sticky error flags, with the received byte held for software
*/
`timescale 1ns/1ns
`include "uart_defines.svh"

module uart_axil_regs import axil_pkg::*; (
  input  logic                        CLK,
  input  logic                        RSTN,
  input  logic [`AXIL_ADDR_WIDTH-1:0] awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [`AXIL_DATA_WIDTH-1:0] wdata,
  input  logic                        wvalid,
  output logic                        wready,
  output logic                        bvalid,
  output axil_resp_t                  bresp,
  input  logic                        bready,
  input  logic [`AXIL_ADDR_WIDTH-1:0] araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic                        rvalid,
  output logic [`AXIL_DATA_WIDTH-1:0] rdata,
  output axil_resp_t                  rresp,
  input  logic                        rready,
  input  logic                        tx_busy,
  output logic                        tx_start,
  output logic [`UART_DATA_WIDTH-1:0] tx_data,
  input  logic [`UART_DATA_WIDTH-1:0] rx_data,
  input  logic                        rx_valid,
  input  logic                        rx_frame_err
);

  localparam int DW  = `AXIL_DATA_WIDTH;
  localparam int UDW = `UART_DATA_WIDTH;

  reg_addr_t      wr_addr;
  reg_addr_t      rd_addr;
  axil_resp_t     wr_resp;
  axil_resp_t     rd_resp;
  logic [DW-1:0]  rd_word;
  logic           wr_accept;
  logic           wr_hs;
  logic           rd_hs;
  logic           rd_done;
  logic           tx_launch;
  logic           status_wr;
  logic [UDW-1:0] rx_byte;
  logic           rx_full;
  logic           overrun;
  logic           frame_err;
  logic           rd_rx_pend;
  logic           rx_clr;
  logic           rx_load;

  assign wr_addr = reg_addr_t'(awaddr);
  assign rd_addr = reg_addr_t'(araddr);
  assign wr_hs   = awvalid && awready && wvalid && wready;
  assign rd_hs   = arvalid && arready;
  assign rd_done = rvalid && rready;

  assign tx_launch = wr_hs && (wr_addr == TX_DATA) && !tx_busy;
  assign status_wr = wr_hs && (wr_addr == STATUS);

  // byte leaves the holding register when its read response completes
  assign rx_clr  = rd_done && rd_rx_pend;
  assign rx_load = rx_valid && (!rx_full || rx_clr);

  always_comb begin
    case (wr_addr)
      TX_DATA: wr_resp = tx_busy ? SLVERR : OKAY;
      RX_DATA: wr_resp = SLVERR;
      STATUS:  wr_resp = OKAY;
      default: wr_resp = SLVERR;
    endcase
  end

  always_comb begin
    rd_word = '0;
    rd_resp = OKAY;
    case (rd_addr)
      TX_DATA: rd_word = '0;
      RX_DATA: rd_word = DW'(rx_byte);
      STATUS:  rd_word = DW'({frame_err, overrun, rx_full, tx_busy});
      default: rd_resp = SLVERR;
    endcase
  end

  // address and data accepted together, one cycle, none while a response waits
  always_ff @(posedge CLK) begin
    if (!RSTN) begin
      wr_accept <= 1'b0;
      bvalid    <= 1'b0;
      tx_start  <= 1'b0;
    end else begin
      wr_accept <= awvalid && wvalid && !wr_accept && !bvalid;
      tx_start  <= tx_launch;
      if (wr_hs) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  assign awready = wr_accept;
  assign wready  = wr_accept;

  always_ff @(posedge CLK) begin
    if (wr_hs) bresp <= wr_resp;
    if (tx_launch) tx_data <= wdata[UDW-1:0];
  end

  always_ff @(posedge CLK) begin
    if (!RSTN) begin
      arready    <= 1'b0;
      rvalid     <= 1'b0;
      rd_rx_pend <= 1'b0;
    end else begin
      arready <= arvalid && !arready && !rvalid;
      if (rd_hs) begin
        rvalid     <= 1'b1;
        rd_rx_pend <= (rd_addr == RX_DATA);
      end else if (rd_done) begin
        rvalid     <= 1'b0;
        rd_rx_pend <= 1'b0;
      end
    end
  end

  // read data captured once and held until rready
  always_ff @(posedge CLK) begin
    if (rd_hs) begin
      rdata <= rd_word;
      rresp <= rd_resp;
    end
  end

  // sticky flags, a new event wins over a same cycle clear
  always_ff @(posedge CLK) begin
    if (!RSTN) begin
      rx_full   <= 1'b0;
      overrun   <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      if (rx_valid && !rx_load) begin
        overrun <= 1'b1;
      end else if (status_wr && wdata[2]) begin
        overrun <= 1'b0;
      end
      if (rx_valid && rx_frame_err) begin
        frame_err <= 1'b1;
      end else if (status_wr && wdata[3]) begin
        frame_err <= 1'b0;
      end
      if (rx_load) begin
        rx_full <= 1'b1;
      end else if (rx_clr) begin
        rx_full <= 1'b0;
      end
    end
  end

  // on overrun the older byte is kept
  always_ff @(posedge CLK) begin
    if (rx_load) rx_byte <= rx_data;
  end

endmodule

// File: source/uart_axil_top.sv
/*
 UART with AXI4-Lite slave: register block, transmitter and receiver
*/
`timescale 1ns/1ns
`include "uart_defines.svh"

module uart_axil_top (
  input  logic                        CLK,
  input  logic                        RSTN,
  input  logic [`AXIL_ADDR_WIDTH-1:0] awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [`AXIL_DATA_WIDTH-1:0] wdata,
  input  logic                        wvalid,
  output logic                        wready,
  output logic                        bvalid,
  output logic [1:0]                  bresp,
  input  logic                        bready,
  input  logic [`AXIL_ADDR_WIDTH-1:0] araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic                        rvalid,
  output logic [`AXIL_DATA_WIDTH-1:0] rdata,
  output logic [1:0]                  rresp,
  input  logic                        rready,
  input  logic                        rxd,
  output logic                        txd
);

  logic                        tx_start;
  logic                        tx_busy;
  logic [`UART_DATA_WIDTH-1:0] tx_data;
  logic [`UART_DATA_WIDTH-1:0] rx_data;
  logic                        rx_valid;
  logic                        rx_frame_err;

  uart_axil_regs u_regs (
    .CLK          (CLK),
    .RSTN         (RSTN),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wvalid       (wvalid),
    .wready       (wready),
    .bvalid       (bvalid),
    .bresp        (bresp),
    .bready       (bready),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rvalid       (rvalid),
    .rdata        (rdata),
    .rresp        (rresp),
    .rready       (rready),
    .tx_busy      (tx_busy),
    .tx_start     (tx_start),
    .tx_data      (tx_data),
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .rx_frame_err (rx_frame_err)
  );

  uart_tx u_tx (
    .CLK      (CLK),
    .RSTN     (RSTN),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .txd      (txd),
    .tx_busy  (tx_busy)
  );

  uart_rx u_rx (
    .CLK          (CLK),
    .RSTN         (RSTN),
    .rxd          (rxd),
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .rx_frame_err (rx_frame_err)
  );

endmodule

// File: source/uart_defines.svh
/*
 UART build-time constants for frame format, bit timing and AXI4-Lite bus widths
*/
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// data bits per serial frame, sent lsb first
`define UART_DATA_WIDTH 8

// clock cycles per bit time, clock frequency divided by baud rate
`define UART_CLKS_PER_BIT 8

// bus address width, byte addressed
`define AXIL_ADDR_WIDTH 4

// bus data width
`define AXIL_DATA_WIDTH 32

`endif

// File: source/uart_line_pkg.sv
/*
 UART serial line types, holding the receiver and transmitter FSM states
*/
package uart_line_pkg;

  // receiver FSM, RX_RESET is only seen for one cycle after reset
  typedef enum logic [2:0] {
    RX_RESET,
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  // transmitter FSM
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

endpackage

// File: source/uart_rx.sv
/*
 UART receiver: detects the start bit, samples each bit at mid-bit,
 checks the stop bit and pulses rx_valid with the received byte
*/
`timescale 1ns/1ns
`include "uart_defines.svh"

module uart_rx import uart_line_pkg::*; (
  input  logic                        CLK,
  input  logic                        RSTN,
  input  logic                        rxd,
  output logic [`UART_DATA_WIDTH-1:0] rx_data,
  output logic                        rx_valid,
  output logic                        rx_frame_err
);

  localparam int DW    = `UART_DATA_WIDTH;
  localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT + 1);
  localparam int IDX_W = $clog2(DW + 1);
  localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(`UART_CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_END = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);
  localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(DW - 1);

  rx_state_t        state;
  rx_state_t        next_state;
  logic [1:0]       rx_sync;
  logic             rx_s;
  logic [CNT_W-1:0] cycle_cnt;
  logic [IDX_W-1:0] bit_idx;
  logic [DW-1:0]    shift_reg;
  logic             cnt_en;
  logic             shift_en;
  logic             bit_end;
  logic             stop_done;

  // two flop synchronizer, the line idles high
  always_ff @(posedge CLK) begin
    if (!RSTN) begin
      rx_sync <= 2'b11;
    end else begin
      rx_sync <= {rx_sync[0], rxd};
    end
  end

  assign rx_s      = rx_sync[1];
  assign bit_end   = (cycle_cnt == BIT_END);
  assign stop_done = (state == RX_STOP) && bit_end;

  always_comb begin
    next_state = state;
    cnt_en     = 1'b0;
    shift_en   = 1'b0;
    case (state)
      RX_RESET: begin
        next_state = RX_IDLE;
      end
      RX_IDLE: begin
        if (!rx_s) next_state = RX_START;
      end
      RX_START: begin
        cnt_en = 1'b1;
        // line went back high before mid start bit, treat as a glitch
        if (rx_s) begin
          next_state = RX_IDLE;
        end else if (cycle_cnt == HALF_END) begin
          next_state = RX_DATA;
          cnt_en     = 1'b0;
        end
      end
      RX_DATA: begin
        cnt_en = 1'b1;
        if (bit_end) begin
          shift_en = 1'b1;
          if (bit_idx == LAST_BIT) begin
            next_state = RX_STOP;
            cnt_en     = 1'b0;
          end
        end
      end
      RX_STOP: begin
        cnt_en = 1'b1;
        if (bit_end) next_state = RX_IDLE;
      end
      default: begin
        next_state = RX_IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!RSTN) begin
      state <= RX_RESET;
    end else begin
      state <= next_state;
    end
  end

  // counts clocks within a bit, wraps at the end of each bit time
  always_ff @(posedge CLK) begin
    if (!RSTN || !cnt_en) begin
      cycle_cnt <= '0;
    end else if (bit_end) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RSTN || state != RX_DATA) begin
      bit_idx <= '0;
    end else if (bit_end) begin
      bit_idx <= bit_idx + 1'b1;
    end
  end

  // lsb arrives first so shift in from the top
  always_ff @(posedge CLK) begin
    if (shift_en) begin
      shift_reg <= {rx_s, shift_reg[DW-1:1]};
    end
  end

  // valid follows the stop bit sample by one cycle
  always_ff @(posedge CLK) begin
    if (!RSTN) begin
      rx_valid     <= 1'b0;
      rx_frame_err <= 1'b0;
    end else begin
      rx_valid     <= stop_done;
      rx_frame_err <= stop_done && !rx_s;
    end
  end

  assign rx_data = shift_reg;

endmodule

// File: source/uart_tx.sv
/*
 UART transmitter: sends start bit, data bits lsb first and stop bit,
 with tx_busy covering the whole frame
*/
`timescale 1ns/1ns
`include "uart_defines.svh"

module uart_tx import uart_line_pkg::*; (
  input  logic                        CLK,
  input  logic                        RSTN,
  input  logic                        tx_start,
  input  logic [`UART_DATA_WIDTH-1:0] tx_data,
  output logic                        txd,
  output logic                        tx_busy
);

  localparam int DW    = `UART_DATA_WIDTH;
  localparam int FW    = DW + 2;
  localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT + 1);
  localparam int IDX_W = $clog2(DW + 1);
  localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(`UART_CLKS_PER_BIT - 1);
  localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(DW - 1);

  tx_state_t        state;
  tx_state_t        next_state;
  logic [CNT_W-1:0] cycle_cnt;
  logic [IDX_W-1:0] bit_idx;
  logic [FW-1:0]    frame;
  logic             bit_end;

  assign bit_end = (cycle_cnt == BIT_END);

  always_comb begin
    next_state = state;
    case (state)
      TX_IDLE: begin
        if (tx_start) next_state = TX_START;
      end
      TX_START: begin
        if (bit_end) next_state = TX_DATA;
      end
      TX_DATA: begin
        if (bit_end && bit_idx == LAST_BIT) next_state = TX_STOP;
      end
      TX_STOP: begin
        if (bit_end) next_state = TX_IDLE;
      end
      default: begin
        next_state = TX_IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!RSTN) begin
      state <= TX_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RSTN || state == TX_IDLE) begin
      cycle_cnt <= '0;
    end else if (bit_end) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RSTN || state != TX_DATA) begin
      bit_idx <= '0;
    end else if (bit_end) begin
      bit_idx <= bit_idx + 1'b1;
    end
  end

  // whole frame in one register, ones shift in behind it so the line
  // is back high once the stop bit has gone out
  always_ff @(posedge CLK) begin
    if (!RSTN) begin
      frame <= '1;
    end else if (state == TX_IDLE && tx_start) begin
      frame <= {1'b1, tx_data, 1'b0};
    end else if (state != TX_IDLE && bit_end) begin
      frame <= {1'b1, frame[FW-1:1]};
    end
  end

  assign txd     = frame[0];
  assign tx_busy = (state != TX_IDLE);

endmodule

// File: tests/uart_assertions.sv
/*
 UART assertions: AXI4-Lite response hold rules, idle serial line and reset state
*/
`timescale 1ns/1ns
`include "uart_defines.svh"

module uart_assertions (
  input logic                        CLK,
  input logic                        RSTN,
  input logic                        bvalid,
  input logic                        bready,
  input logic                        rvalid,
  input logic                        rready,
  input logic [`AXIL_DATA_WIDTH-1:0] rdata,
  input logic                        txd,
  input logic                        tx_busy,
  input logic                        awready,
  input logic                        arready
);

  // write response waits for the master
  bvalid_held: assert property (@(posedge CLK) disable iff (!RSTN)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  // read data must not move under back-pressure
  rdata_stable: assert property (@(posedge CLK) disable iff (!RSTN)
    rvalid && !rready |=> $stable(rdata))
    else $error("rdata changed while rvalid high and rready low");

  txd_idle_high: assert property (@(posedge CLK) disable iff (!RSTN)
    !tx_busy |-> txd)
    else $error("txd low while transmitter idle");

  ready_low_in_reset: assert property (@(posedge CLK)
    !RSTN |=> !awready && !arready)
    else $error("awready or arready high during reset");

endmodule

// File: tests/uart_tb.sv
/*
 Directed testbench for the AXI4-Lite UART covering bus access, transmit
 and receive frames, sticky flags and bus error responses
*/
`timescale 1ns/1ns
`include "uart_defines.svh"

module uart_tb import axil_pkg::*; ();

  localparam int CPB        = `UART_CLKS_PER_BIT;
  localparam int UDW        = `UART_DATA_WIDTH;
  localparam int AW         = `AXIL_ADDR_WIDTH;
  localparam int DW         = `AXIL_DATA_WIDTH;
  localparam int BUS_LIMIT  = 50;
  localparam int LINE_LIMIT = 40 * CPB;
  localparam int POLL_LIMIT = 40;

  logic          CLK = 1'b0;
  logic          RSTN;
  logic [AW-1:0] awaddr;
  logic          awvalid;
  logic          awready;
  logic [DW-1:0] wdata;
  logic          wvalid;
  logic          wready;
  logic          bvalid;
  logic [1:0]    bresp;
  logic          bready;
  logic [AW-1:0] araddr;
  logic          arvalid;
  logic          arready;
  logic          rvalid;
  logic [DW-1:0] rdata;
  logic [1:0]    rresp;
  logic          rready;
  logic          rxd;
  logic          txd;
  int            errors = 0;
  int            checks = 0;

  always #2 CLK = ~CLK;

  uart_axil_top uut (
    .CLK     (CLK),
    .RSTN    (RSTN),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bresp   (bresp),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rvalid  (rvalid),
    .rdata   (rdata),
    .rresp   (rresp),
    .rready  (rready),
    .rxd     (rxd),
    .txd     (txd)
  );

  bind uart_axil_top uart_assertions u_assertions (
    .CLK     (CLK),
    .RSTN    (RSTN),
    .bvalid  (bvalid),
    .bready  (bready),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .txd     (txd),
    .tx_busy (tx_busy),
    .awready (awready),
    .arready (arready)
  );

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    end
  endtask

  // STATUS holds frame_err, overrun, rx_valid and tx_busy from bit 3 down
  function automatic logic [31:0] status_word(input logic busy, input logic full,
                                              input logic ovr, input logic ferr);
    return {28'd0, ferr, ovr, full, busy};
  endfunction

  function automatic logic [UDW-1:0] random_byte();
    return UDW'($urandom);
  endfunction

  task automatic axil_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                            output logic [1:0] resp);
    int wait_cnt;
    resp = 2'bxx;
    @(posedge CLK);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    wait_cnt = 0;
    @(negedge CLK);
    while (!(awready && wready) && wait_cnt < BUS_LIMIT) begin
      @(negedge CLK);
      wait_cnt++;
    end
    if (!(awready && wready)) begin
      errors++;
      $display("write to 0x%0h was never accepted", addr);
    end
    @(posedge CLK);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    wait_cnt = 0;
    @(negedge CLK);
    while (!bvalid && wait_cnt < BUS_LIMIT) begin
      @(negedge CLK);
      wait_cnt++;
    end
    if (bvalid) begin
      resp = bresp;
    end else begin
      errors++;
      $display("no write response for address 0x%0h", addr);
    end
    // bready comes one cycle late so the response has to wait for it
    @(posedge CLK);
    bready <= 1'b1;
    @(posedge CLK);
    bready <= 1'b0;
  endtask

  // hold keeps rready low for that many cycles once rvalid is up
  task automatic axil_read(input logic [AW-1:0] addr, input int hold,
                           output logic [DW-1:0] data, output logic [1:0] resp);
    int wait_cnt;
    data = 'x;
    resp = 2'bxx;
    @(posedge CLK);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= (hold == 0);
    wait_cnt = 0;
    @(negedge CLK);
    while (!arready && wait_cnt < BUS_LIMIT) begin
      @(negedge CLK);
      wait_cnt++;
    end
    if (!arready) begin
      errors++;
      $display("read of 0x%0h was never accepted", addr);
    end
    @(posedge CLK);
    arvalid <= 1'b0;
    wait_cnt = 0;
    @(negedge CLK);
    while (!rvalid && wait_cnt < BUS_LIMIT) begin
      @(negedge CLK);
      wait_cnt++;
    end
    if (!rvalid) begin
      errors++;
      $display("no read response for address 0x%0h", addr);
    end
    data = rdata;
    resp = rresp;
    repeat (hold) begin
      @(negedge CLK);
      check("rdata under back-pressure", data, rdata);
      check("rvalid under back-pressure", 32'h1, rvalid);
    end
    if (hold > 0) begin
      @(posedge CLK);
      rready <= 1'b1;
    end
    @(posedge CLK);
    rready <= 1'b0;
  endtask

  task automatic wait_status(input int bit_pos, input string what);
    logic [DW-1:0] data;
    logic [1:0]    resp;
    int            polls;
    polls = 0;
    axil_read(STATUS, 0, data, resp);
    while (data[bit_pos] !== 1'b1 && polls < POLL_LIMIT) begin
      axil_read(STATUS, 0, data, resp);
      polls++;
    end
    if (data[bit_pos] !== 1'b1) begin
      errors++;
      $display("%s never showed up in STATUS", what);
    end
  endtask

  task automatic send_frame(input logic [UDW-1:0] data, input logic stop_bit);
    @(posedge CLK);
    rxd <= 1'b0;
    repeat (CPB - 1) @(posedge CLK);
    for (int i = 0; i < UDW; i++) begin
      @(posedge CLK);
      rxd <= data[i];
      repeat (CPB - 1) @(posedge CLK);
    end
    @(posedge CLK);
    rxd <= stop_bit;
    repeat (CPB - 1) @(posedge CLK);
    @(posedge CLK);
    rxd <= 1'b1;
  endtask

  task automatic send_glitch(input int cycles);
    @(posedge CLK);
    rxd <= 1'b0;
    repeat (cycles) @(posedge CLK);
    rxd <= 1'b1;
  endtask

  // finds the falling edge and samples each bit near its middle
  task automatic capture_frame(output logic [UDW-1:0] data, output logic stop_bit);
    int wait_cnt;
    data     = 'x;
    stop_bit = 1'bx;
    wait_cnt = 0;
    @(negedge CLK);
    while (txd && wait_cnt < LINE_LIMIT) begin
      @(negedge CLK);
      wait_cnt++;
    end
    if (txd) begin
      errors++;
      $display("no start bit seen on txd");
    end else begin
      repeat (CPB / 2 - 1) @(negedge CLK);
      check("txd start bit", 32'h0, txd);
      for (int i = 0; i < UDW; i++) begin
        repeat (CPB) @(negedge CLK);
        data[i] = txd;
      end
      repeat (CPB) @(negedge CLK);
      stop_bit = txd;
    end
  endtask

  task automatic check_line_idle(input int cycles);
    int lows;
    lows = 0;
    repeat (cycles) begin
      @(negedge CLK);
      if (txd !== 1'b1) lows++;
    end
    check("txd low samples while idle", 32'h0, lows);
  endtask

  task automatic read_reset_state();
    logic [DW-1:0] data;
    logic [1:0]    resp;
    axil_read(STATUS, 0, data, resp);
    check("STATUS after reset", status_word(1'b0, 1'b0, 1'b0, 1'b0), data);
    check("rresp STATUS", 32'(OKAY), resp);
    check("txd after reset", 32'h1, txd);
  endtask

  task automatic transmit_byte();
    logic [UDW-1:0] tx_byte;
    logic [UDW-1:0] got;
    logic           stop_bit;
    logic [DW-1:0]  data;
    logic [1:0]     resp;
    tx_byte = random_byte();
    axil_write(TX_DATA, DW'(tx_byte), resp);
    check("bresp TX_DATA", 32'(OKAY), resp);
    fork
      capture_frame(got, stop_bit);
      begin
        repeat (3 * CPB) @(posedge CLK);
        axil_read(STATUS, 0, data, resp);
        check("tx_busy during frame", 32'h1, data[0]);
      end
    join
    check("txd data", 32'(tx_byte), got);
    check("txd stop bit", 32'h1, stop_bit);
    // let the stop bit run out
    repeat (CPB) @(posedge CLK);
    axil_read(STATUS, 0, data, resp);
    check("tx_busy after frame", 32'h0, data[0]);
  endtask

  task automatic receive_byte();
    logic [UDW-1:0] rx_byte;
    logic [DW-1:0]  data;
    logic [1:0]     resp;
    rx_byte = random_byte();
    send_frame(rx_byte, 1'b1);
    wait_status(1, "rx_valid");
    axil_read(RX_DATA, 0, data, resp);
    check("RX_DATA", 32'(rx_byte), data);
    check("rresp RX_DATA", 32'(OKAY), resp);
    axil_read(STATUS, 0, data, resp);
    check("STATUS after RX_DATA read", status_word(1'b0, 1'b0, 1'b0, 1'b0), data);
    // a low pulse under half a bit must not start a frame
    send_glitch(CPB / 4);
    repeat (5) begin
      repeat (2 * CPB) @(posedge CLK);
      axil_read(STATUS, 0, data, resp);
      check("rx_valid after glitch", 32'h0, data[1]);
    end
  endtask

  task automatic overrun_and_frame_error();
    logic [UDW-1:0] first;
    logic [UDW-1:0] second;
    logic [UDW-1:0] bad;
    logic [DW-1:0]  data;
    logic [1:0]     resp;
    first  = random_byte();
    second = random_byte();
    bad    = random_byte();
    send_frame(first, 1'b1);
    send_frame(second, 1'b1);
    wait_status(2, "overrun");
    axil_read(STATUS, 0, data, resp);
    check("STATUS after overrun", status_word(1'b0, 1'b1, 1'b1, 1'b0), data);
    axil_read(RX_DATA, 0, data, resp);
    check("RX_DATA keeps first byte", 32'(first), data);
    send_frame(bad, 1'b0);
    wait_status(3, "frame_err");
    axil_read(STATUS, 0, data, resp);
    check("STATUS after bad stop bit", status_word(1'b0, 1'b1, 1'b1, 1'b1), data);
    axil_read(RX_DATA, 0, data, resp);
    check("RX_DATA with frame error", 32'(bad), data);
    axil_write(STATUS, 32'hC, resp);
    check("bresp STATUS", 32'(OKAY), resp);
    axil_read(STATUS, 0, data, resp);
    check("STATUS after clear", status_word(1'b0, 1'b0, 1'b0, 1'b0), data);
  endtask

  task automatic bus_error_responses();
    logic [UDW-1:0] first;
    logic [UDW-1:0] second;
    logic [UDW-1:0] rx_byte;
    logic [UDW-1:0] got;
    logic           stop_bit;
    logic [DW-1:0]  data;
    logic [1:0]     resp;
    logic [1:0]     busy_resp;
    axil_read(4'hC, 0, data, resp);
    check("rresp unmapped", 32'(SLVERR), resp);
    axil_write(RX_DATA, 32'h55, resp);
    check("bresp RX_DATA write", 32'(SLVERR), resp);
    first  = random_byte();
    second = random_byte();
    axil_write(TX_DATA, DW'(first), resp);
    check("bresp first TX_DATA", 32'(OKAY), resp);
    fork
      capture_frame(got, stop_bit);
      axil_write(TX_DATA, DW'(second), busy_resp);
    join
    check("bresp TX_DATA while busy", 32'(SLVERR), busy_resp);
    check("txd data with dropped write", 32'(first), got);
    check("txd stop bit", 32'h1, stop_bit);
    // the dropped byte must never reach the line
    check_line_idle(10 * CPB);
    rx_byte = random_byte();
    send_frame(rx_byte, 1'b1);
    wait_status(1, "rx_valid");
    axil_read(RX_DATA, 6, data, resp);
    check("RX_DATA under back-pressure", 32'(rx_byte), data);
    check("rresp under back-pressure", 32'(OKAY), resp);
  endtask

  initial begin
    void'($urandom(32'h8cad));
    // requests stay pending through reset and must not be accepted
    RSTN    = 1'b0;
    awaddr  = '0;
    awvalid = 1'b1;
    wdata   = '0;
    wvalid  = 1'b1;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b1;
    rready  = 1'b0;
    rxd     = 1'b1;
    repeat (10) @(posedge CLK);
    RSTN    <= 1'b1;
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    arvalid <= 1'b0;
    repeat (2) @(posedge CLK);
    read_reset_state();
    transmit_byte();
    receive_byte();
    overrun_and_frame_error();
    bus_error_responses();
    repeat (4) @(posedge CLK);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
